/* hw/isa_pkg.sv */
// Instruction-format types, pipeline selectors and latencies shared by the issue logic and testbench
package isa_pkg;

	// Register number within one register file, scalar or vector
	typedef logic [4:0] reg_idx_t;

	// Execution pipeline that an instruction is steered to
	typedef enum logic [1:0]
	{
		PIPE_SCYCLE_ARITH = 2'd0,
		PIPE_MCYCLE_ARITH = 2'd1,
		PIPE_MEM = 2'd2
	} pipeline_sel_t;

	// Cycles from the issue output being valid to the writeback slot of that instruction
	localparam int LAT_SCYCLE = 1;
	localparam int LAT_MCYCLE = 4;
	localparam int LAT_MEM = 2;

	// Writeback slot tracker length, enough to reach the slot of the longest pipeline
	localparam int WB_SLOTS = LAT_MCYCLE + 1;

	// Busy bitmap width: scalar registers in the low half, vector registers in the high half
	localparam int SCOREBOARD_BITS = 64;

	// One decoded instruction as it leaves the decoder and enters the thread FIFOs
	typedef struct packed
	{
		pipeline_sel_t pipeline_sel;
		logic has_dest;
		logic dest_is_vector;
		reg_idx_t dest_reg;
		logic has_src1;
		logic src1_is_vector;
		reg_idx_t src1_reg;
		logic has_src2;
		logic src2_is_vector;
		reg_idx_t src2_reg;
		logic [15:0] payload;
	} decoded_instruction_t;

endpackage

/* hw/core_pkg.sv */
// Core organization constants and thread-level record types used by the issue stage and testbench
package core_pkg;

	// Number of hardware threads sharing the issue stage
	localparam int NUM_THREADS = 4;

	// Depth of each per-thread instruction FIFO
	localparam int THREAD_FIFO_SIZE = 5;

	// Occupancy at which the fetch enable of a thread drops
	// Two spare entries absorb instructions already in flight from the front end
	localparam int FIFO_ALMOST_FULL = 3;

	typedef logic [1:0] thread_idx_t;

	typedef logic [NUM_THREADS-1:0] thread_mask_t;

	// Register writeback reported by the execution pipelines
	// The register field is named reg_idx because reg is a reserved word
	typedef struct packed
	{
		logic en;
		thread_idx_t thread_idx;
		logic is_vector;
		isa_pkg::reg_idx_t reg_idx;
	} writeback_t;

endpackage

/* hw/sync_fifo.sv */
// Synchronous FIFO with a combinational head and an almost-full flag, used as a per-thread queue
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4,
	parameter int ALMOST_FULL_THRESHOLD = 3
)(
	input clk,
	input reset,
	input enqueue_en,
	input [WIDTH-1:0] enqueue_value,
	input dequeue_en,
	output logic [WIDTH-1:0] head_value,
	output logic empty,
	output logic almost_full
);

	localparam int PTR_WIDTH = DEPTH > 1 ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic full;

	assign empty = count == '0;
	assign full = count == COUNT_WIDTH'(DEPTH);
	assign almost_full = count >= COUNT_WIDTH'(ALMOST_FULL_THRESHOLD);

	// The oldest entry is visible without waiting for a dequeue
	assign head_value = storage[read_ptr];

	// Storage carries only payload, so it is written without a reset
	always_ff @(posedge clk)
	begin
		if (enqueue_en)
			storage[write_ptr] <= enqueue_value;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (enqueue_en)
				write_ptr <= write_ptr == PTR_WIDTH'(DEPTH - 1) ? '0 : write_ptr + 1'b1;

			if (dequeue_en)
				read_ptr <= read_ptr == PTR_WIDTH'(DEPTH - 1) ? '0 : read_ptr + 1'b1;

			// Simultaneous enqueue and dequeue leave the count unchanged
			if (enqueue_en && !dequeue_en)
				count <= count + 1'b1;
			else if (dequeue_en && !enqueue_en)
				count <= count - 1'b1;
		end
	end

	// The producer honours almost_full, so a write into a full queue is a protocol error
	assert property (@(posedge clk) disable iff (reset) enqueue_en |-> !full);

	// The consumer only dequeues what it has seen at the head
	assert property (@(posedge clk) disable iff (reset) dequeue_en |-> !empty);

endmodule

/* hw/rr_arbiter.sv */
// Round-robin arbiter granting one requester per cycle with rotating priority
`timescale 1ns/100ps

module rr_arbiter #(
	parameter int NUM_REQUESTERS = 4
)(
	input clk,
	input reset,
	input [NUM_REQUESTERS-1:0] request,
	output logic [NUM_REQUESTERS-1:0] grant_oh
);

	localparam int IDX_WIDTH = NUM_REQUESTERS > 1 ? $clog2(NUM_REQUESTERS) : 1;

	logic [IDX_WIDTH-1:0] last_grant_idx;
	logic [IDX_WIDTH-1:0] grant_idx;

	// Search starts just after the last granted requester and wraps around
	always_comb
	begin
		int candidate;
		grant_oh = '0;
		grant_idx = last_grant_idx;
		for (int i = 1; i <= NUM_REQUESTERS; i++)
		begin
			candidate = (int'(last_grant_idx) + i) % NUM_REQUESTERS;
			if (request[candidate] && grant_oh == '0)
			begin
				grant_oh[candidate] = 1'b1;
				grant_idx = IDX_WIDTH'(candidate);
			end
		end
	end

	// Priority only moves when someone wins, so an idle cycle keeps the order
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant_idx <= IDX_WIDTH'(NUM_REQUESTERS - 1);
		else if (|grant_oh)
			last_grant_idx <= grant_idx;
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh) && (grant_oh & ~request) == '0);

endmodule

/* hw/thread_ctrl_regs.sv */
// Control register holding the thread-enable mask, loaded by a software write strobe
`timescale 1ns/100ps

module thread_ctrl_regs (
	input clk,
	input reset,

	// Software write port
	input cr_write_en,
	input core_pkg::thread_mask_t cr_write_data,

	// Steers both issue eligibility and fetch enable in the select stage
	output core_pkg::thread_mask_t thread_enable
);

	// All threads start disabled until software writes the mask
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			thread_enable <= '0;
		else if (cr_write_en)
			thread_enable <= cr_write_data;
	end

endmodule

/* hw/thread_select_stage.sv */
// Thread select stage: per-thread queues and scoreboards, writeback slot tracking and issue register
`timescale 1ns/100ps

module thread_select_stage (
	input clk,
	input reset,

	// From decode
	input isa_pkg::decoded_instruction_t id_instruction,
	input id_valid,
	input core_pkg::thread_idx_t id_thread_idx,

	// From control registers
	input core_pkg::thread_mask_t thread_enable,

	// From execution pipelines
	input core_pkg::writeback_t wb,

	// To fetch
	output core_pkg::thread_mask_t fetch_en,

	// To execution pipelines
	output logic ts_valid,
	output isa_pkg::decoded_instruction_t ts_instruction,
	output core_pkg::thread_idx_t ts_thread_idx
);

	import isa_pkg::*;
	import core_pkg::*;

	decoded_instruction_t thread_head [NUM_THREADS];
	decoded_instruction_t issue_instr;
	thread_mask_t can_issue;
	thread_mask_t grant_oh;
	thread_idx_t issue_thread_idx;

	// Bit k is set when a writeback is already booked k + 1 cycles from now
	logic [WB_SLOTS-1:0] wb_slot;
	logic [WB_SLOTS-1:0] wb_slot_nxt;

	// One-hot scoreboard position of a register, vector registers in the upper half
	function automatic logic [SCOREBOARD_BITS-1:0] reg_bit(input logic is_vector,
		input reg_idx_t idx);
		return SCOREBOARD_BITS'(1) << {is_vector, idx};
	endfunction

	function automatic int pipe_latency(input pipeline_sel_t sel);
		case (sel)
			PIPE_SCYCLE_ARITH: return LAT_SCYCLE;
			PIPE_MCYCLE_ARITH: return LAT_MCYCLE;
			default: return LAT_MEM;
		endcase
	endfunction

	for (genvar t = 0; t < NUM_THREADS; t++)
	begin : thread_logic
		logic fifo_empty;
		logic fifo_almost_full;
		logic wb_conflict;
		logic [SCOREBOARD_BITS-1:0] scoreboard;
		logic [SCOREBOARD_BITS-1:0] dest_bitmap;
		logic [SCOREBOARD_BITS-1:0] dep_bitmap;
		logic [SCOREBOARD_BITS-1:0] clear_bitmap;
		decoded_instruction_t head;

		sync_fifo #(
			.WIDTH($bits(decoded_instruction_t)),
			.DEPTH(THREAD_FIFO_SIZE),
			.ALMOST_FULL_THRESHOLD(FIFO_ALMOST_FULL)
		) u_instruction_fifo (
			.clk(clk),
			.reset(reset),
			.enqueue_en(id_valid && id_thread_idx == thread_idx_t'(t)),
			.enqueue_value(id_instruction),
			.dequeue_en(grant_oh[t]),
			.head_value(thread_head[t]),
			.empty(fifo_empty),
			.almost_full(fifo_almost_full)
		);

		assign head = thread_head[t];

		// Fetch stops early enough that in-flight instructions still fit
		assign fetch_en[t] = thread_enable[t] && !fifo_almost_full;

		assign dest_bitmap = head.has_dest ? reg_bit(head.dest_is_vector, head.dest_reg) : '0;

		// Sources catch read-after-write, the destination catches write-after-write
		assign dep_bitmap = dest_bitmap
			| (head.has_src1 ? reg_bit(head.src1_is_vector, head.src1_reg) : '0)
			| (head.has_src2 ? reg_bit(head.src2_is_vector, head.src2_reg) : '0);

		always_comb
		begin
			clear_bitmap = '0;
			if (wb.en && wb.thread_idx == thread_idx_t'(t))
				clear_bitmap = reg_bit(wb.is_vector, wb.reg_idx);
		end

		// The head would land on the writeback port in a slot someone already owns
		assign wb_conflict = wb_slot[pipe_latency(head.pipeline_sel)];

		// Registered scoreboard is checked, so a writeback frees its register next cycle
		assign can_issue[t] = !fifo_empty
			&& thread_enable[t]
			&& (scoreboard & dep_bitmap) == '0
			&& !wb_conflict;

		always_ff @(posedge clk, posedge reset)
		begin
			if (reset)
				scoreboard <= '0;
			else
				scoreboard <= (scoreboard & ~clear_bitmap) | (grant_oh[t] ? dest_bitmap : '0);
		end

		// A writeback must retire a register that an earlier issue marked busy
		assert property (@(posedge clk) disable iff (reset)
			(wb.en && wb.thread_idx == thread_idx_t'(t)) |-> (scoreboard & clear_bitmap) != '0);
	end

	rr_arbiter #(
		.NUM_REQUESTERS(NUM_THREADS)
	) u_thread_arbiter (
		.clk(clk),
		.reset(reset),
		.request(can_issue),
		.grant_oh(grant_oh)
	);

	always_comb
	begin
		issue_thread_idx = '0;
		for (int i = 0; i < NUM_THREADS; i++)
			if (grant_oh[i])
				issue_thread_idx = thread_idx_t'(i);
	end

	assign issue_instr = thread_head[issue_thread_idx];

	// Advance the booking window by one and book the slot of this cycle's issue
	// Every issued instruction books its slot, even without a destination register
	always_comb
	begin
		wb_slot_nxt = {1'b0, wb_slot[WB_SLOTS-1:1]};
		if (|grant_oh)
			wb_slot_nxt[pipe_latency(issue_instr.pipeline_sel) - 1] = 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ts_valid <= 1'b0;
			wb_slot <= '0;
		end
		else
		begin
			ts_valid <= |grant_oh;
			wb_slot <= wb_slot_nxt;
		end
	end

	// Issue payload is qualified by ts_valid
	always_ff @(posedge clk)
	begin
		ts_instruction <= issue_instr;
		ts_thread_idx <= issue_thread_idx;
	end

endmodule

/* hw/thread_issue_top.sv */
// Top level of the thread issue stage joining the control registers to the select stage
`timescale 1ns/100ps

module thread_issue_top (
	input clk,
	input reset,

	// Decode side
	input isa_pkg::decoded_instruction_t id_instruction,
	input id_valid,
	input core_pkg::thread_idx_t id_thread_idx,

	// Control register write port
	input cr_write_en,
	input core_pkg::thread_mask_t cr_write_data,

	// Writeback from the execution pipelines
	input core_pkg::writeback_t wb,

	// Fetch throttle
	output core_pkg::thread_mask_t fetch_en,

	// Issue side
	output logic ts_valid,
	output isa_pkg::decoded_instruction_t ts_instruction,
	output core_pkg::thread_idx_t ts_thread_idx
);

	import core_pkg::*;

	thread_mask_t thread_enable;

	thread_ctrl_regs u_thread_ctrl_regs (
		.clk(clk),
		.reset(reset),
		.cr_write_en(cr_write_en),
		.cr_write_data(cr_write_data),
		.thread_enable(thread_enable)
	);

	thread_select_stage u_thread_select_stage (
		.clk(clk),
		.reset(reset),
		.id_instruction(id_instruction),
		.id_valid(id_valid),
		.id_thread_idx(id_thread_idx),
		.thread_enable(thread_enable),
		.wb(wb),
		.fetch_en(fetch_en),
		.ts_valid(ts_valid),
		.ts_instruction(ts_instruction),
		.ts_thread_idx(ts_thread_idx)
	);

endmodule

/* tb/thread_issue_tb.sv */
// Testbench for the thread issue stage, checking random traffic against queue, scoreboard and slot models
`timescale 1ns/100ps

module thread_issue_tb;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int TRAFFIC_CYCLES = 400;
	localparam int DISABLED_CYCLES = 200;
	localparam int STIM_CYCLES = TRAFFIC_CYCLES + DISABLED_CYCLES + 20;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;
	// Writeback ring, longer than the longest pipeline latency
	localparam int RING = 8;

	logic clk = 1'b0;
	logic reset;
	decoded_instruction_t id_instruction;
	logic id_valid;
	thread_idx_t id_thread_idx;
	logic cr_write_en;
	thread_mask_t cr_write_data;
	writeback_t wb;
	thread_mask_t fetch_en;
	logic ts_valid;
	decoded_instruction_t ts_instruction;
	thread_idx_t ts_thread_idx;

	integer seed = 32'h3096_a2df;
	int cyc;
	int watchdog;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;
	int enqueued;
	int issued;

	// Model of the thread queues, busy registers and booked writeback cycles
	decoded_instruction_t model_queue [NUM_THREADS][$];
	logic [63:0] busy [NUM_THREADS];
	logic slot_used [RING];
	writeback_t slot_wb [RING];
	writeback_t last_wb;
	// Enable mask seen by the DUT in this cycle and in the one before
	thread_mask_t enable_now;
	thread_mask_t enable_prev;
	thread_mask_t prev_fetch_en;

	thread_issue_top u_thread_issue_top (
		.clk(clk),
		.reset(reset),
		.id_instruction(id_instruction),
		.id_valid(id_valid),
		.id_thread_idx(id_thread_idx),
		.cr_write_en(cr_write_en),
		.cr_write_data(cr_write_data),
		.wb(wb),
		.fetch_en(fetch_en),
		.ts_valid(ts_valid),
		.ts_instruction(ts_instruction),
		.ts_thread_idx(ts_thread_idx)
	);

	always #5 clk = ~clk;

	function automatic int latency_of(input pipeline_sel_t sel);
		if (sel == PIPE_SCYCLE_ARITH)
			return LAT_SCYCLE;
		else if (sel == PIPE_MCYCLE_ARITH)
			return LAT_MCYCLE;
		return LAT_MEM;
	endfunction

	// Scalar registers occupy 0 to 31, vector registers 32 to 63
	function automatic int bit_pos(input logic is_vector, input reg_idx_t r);
		return (is_vector ? 32 : 0) + int'(r);
	endfunction

	function automatic logic names_busy(input thread_idx_t t, input decoded_instruction_t ins);
		logic hit;
		hit = 1'b0;
		if (ins.has_dest && busy[t][bit_pos(ins.dest_is_vector, ins.dest_reg)])
			hit = 1'b1;
		if (ins.has_src1 && busy[t][bit_pos(ins.src1_is_vector, ins.src1_reg)])
			hit = 1'b1;
		if (ins.has_src2 && busy[t][bit_pos(ins.src2_is_vector, ins.src2_reg)])
			hit = 1'b1;
		return hit;
	endfunction

	function automatic logic work_pending();
		logic pending;
		pending = 1'b0;
		for (int t = 0; t < NUM_THREADS; t++)
			if (model_queue[t].size() != 0)
				pending = 1'b1;
		for (int s = 0; s < RING; s++)
			if (slot_used[s])
				pending = 1'b1;
		return pending;
	endfunction

	task automatic value_mismatch(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic note_problem(input string msg);
		$display("Problem at %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, test_errors);
		if (test_errors == 0)
			tests_passed++;
		else
			tests_failed++;
		test_errors = 0;
	endtask

	// Compares this cycle's registered outputs with the model, then advances the model
	task automatic check_outputs();
		thread_idx_t t;
		int slot;
		t = ts_thread_idx;
		if (ts_valid)
		begin
			issued++;
			// Grant was decided last cycle, under last cycle's mask and scoreboard
			assert (enable_prev[t])
			else note_problem($sformatf("thread %0d issued while disabled", t));
			assert (!names_busy(t, ts_instruction))
			else note_problem($sformatf("thread %0d issued with a busy register", t));
			assert (model_queue[t].size() != 0)
			else note_problem($sformatf("thread %0d issued with nothing queued", t));
			if (model_queue[t].size() != 0)
			begin
				assert (ts_instruction == model_queue[t][0])
				else value_mismatch($sformatf("thread %0d issued %h, expected %h",
					t, ts_instruction, model_queue[t][0]));
				void'(model_queue[t].pop_front());
			end
			slot = (cyc + latency_of(ts_instruction.pipeline_sel)) % RING;
			assert (!slot_used[slot])
			else note_problem("two issued instructions share one writeback slot");
			slot_used[slot] = 1'b1;
			slot_wb[slot].en = ts_instruction.has_dest;
			slot_wb[slot].thread_idx = t;
			slot_wb[slot].is_vector = ts_instruction.dest_is_vector;
			slot_wb[slot].reg_idx = ts_instruction.dest_reg;
		end
		// Last cycle's writeback frees its register only from this cycle on
		if (last_wb.en)
			busy[last_wb.thread_idx][bit_pos(last_wb.is_vector, last_wb.reg_idx)] = 1'b0;
		if (ts_valid && ts_instruction.has_dest)
			busy[t][bit_pos(ts_instruction.dest_is_vector, ts_instruction.dest_reg)] = 1'b1;
		for (int i = 0; i < NUM_THREADS; i++)
			assert (fetch_en[i] == (enable_now[i] && model_queue[i].size() < FIFO_ALMOST_FULL))
			else value_mismatch($sformatf("fetch_en[%0d] is %b with %0d queued", i,
				fetch_en[i], model_queue[i].size()));
	endtask

	task automatic drive_inputs(input bit gen, input bit do_write, input thread_mask_t mask);
		int r;
		int bits;
		int unsigned pick;
		thread_idx_t t;
		decoded_instruction_t ins;
		// Play the execution pipelines by returning the writeback booked for this cycle
		wb = '0;
		if (slot_used[cyc % RING])
		begin
			wb = slot_wb[cyc % RING];
			slot_used[cyc % RING] = 1'b0;
		end
		last_wb = wb;
		id_valid = 1'b0;
		r = $random(seed);
		t = thread_idx_t'(r);
		// The front end only sends to threads whose fetch enable was high last cycle
		if (gen && r[5:3] != 3'd0 && prev_fetch_en[t])
		begin
			pick = $unsigned($random(seed));
			bits = $random(seed);
			ins.pipeline_sel = pipeline_sel_t'(pick % 3);
			// Registers 0 to 3 only, so dependencies come up often
			ins.has_dest = bits[0] | bits[12];
			ins.dest_is_vector = bits[1];
			ins.dest_reg = reg_idx_t'(bits[3:2]);
			ins.has_src1 = bits[4];
			ins.src1_is_vector = bits[5];
			ins.src1_reg = reg_idx_t'(bits[7:6]);
			ins.has_src2 = bits[8];
			ins.src2_is_vector = bits[9];
			ins.src2_reg = reg_idx_t'(bits[11:10]);
			ins.payload = bits[31:16];
			id_instruction = ins;
			id_thread_idx = t;
			id_valid = 1'b1;
			model_queue[t].push_back(ins);
			enqueued++;
		end
		prev_fetch_en = fetch_en;
		enable_prev = enable_now;
		cr_write_en = do_write;
		cr_write_data = mask;
		if (do_write)
			enable_now = mask;
	endtask

	task automatic run_cycle(input bit gen, input bit do_write, input thread_mask_t mask);
		@(negedge clk);
		cyc++;
		check_outputs();
		drive_inputs(gen, do_write, mask);
	endtask

	initial
	begin
		reset = 1'b1;
		id_instruction = '0;
		id_valid = 1'b0;
		id_thread_idx = '0;
		cr_write_en = 1'b0;
		cr_write_data = '0;
		wb = '0;
		last_wb = '0;
		enable_now = '0;
		enable_prev = '0;
		prev_fetch_en = '0;
		for (int t = 0; t < NUM_THREADS; t++)
			busy[t] = '0;
		for (int s = 0; s < RING; s++)
			slot_used[s] = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		// Nothing issues and nothing is fetched until software writes the mask
		repeat (3)
		begin
			run_cycle(1'b0, 1'b0, '0);
			assert (!ts_valid && fetch_en == '0)
			else value_mismatch($sformatf("ts_valid %b fetch_en %b after reset", ts_valid, fetch_en));
		end
		run_cycle(1'b0, 1'b1, 4'b1111);
		run_cycle(1'b0, 1'b0, '0);
		assert (fetch_en == 4'b1111)
		else value_mismatch($sformatf("fetch_en %b one cycle after mask write", fetch_en));
		end_test("reset_state");

		repeat (TRAFFIC_CYCLES) run_cycle(1'b1, 1'b0, '0);
		end_test("random_traffic");

		// Thread 1 stops with whatever it has queued
		run_cycle(1'b1, 1'b1, 4'b1101);
		repeat (DISABLED_CYCLES) run_cycle(1'b1, 1'b0, '0);
		end_test("thread_disable");

		run_cycle(1'b0, 1'b1, 4'b1111);
		while (work_pending())
			run_cycle(1'b0, 1'b0, '0);
		repeat (10) run_cycle(1'b0, 1'b0, '0);
		assert (enqueued == issued)
		else value_mismatch($sformatf("%0d enqueued but %0d issued", enqueued, issued));
		end_test("drain_after_reenable");

		$display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		watchdog = 0;
		while (watchdog < CYCLE_LIMIT)
		begin
			@(posedge clk);
			watchdog++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

endmodule

/* thread_issue.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/sync_fifo.sv
hw/rr_arbiter.sv
hw/thread_ctrl_regs.sv
hw/thread_select_stage.sv
hw/thread_issue_top.sv
tb/thread_issue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the thread issue testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module thread_issue_tb -f thread_issue.f -o thread_issue_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/thread_issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0
